//--- files.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/reg_file.sv
hdl/ctrl_decode.sv
hdl/imm_gen.sv
hdl/operand_forward.sv
hdl/branch_unit.sv
hdl/pipe_reg.sv
hdl/id_stage.sv
tb/tb_id_stage.sv

//--- hdl/branch_unit.sv
`timescale 1ns/100ps
`include "id_macros.svh"

module branch_unit (
    input  logic [`ID_XLEN-1:0] pc_i,
    input  logic [`ID_XLEN-1:0] rs1_i,
    input  logic [`ID_XLEN-1:0] rs2_i,
    input  logic [`ID_XLEN-1:0] imm_i,
    input  isa_pkg::br_funct3_e funct3_i,
    input  logic                is_branch_i,
    input  logic                is_jal_i,
    input  logic                is_jalr_i,
    input  logic                is_lui_i,
    output pipe_pkg::redirect_t redirect_o,
    output logic [`ID_XLEN-1:0] link_o
);

    logic                cond;
    logic [`ID_XLEN-1:0] jalr_sum;

    always_comb begin
        case (funct3_i)
            isa_pkg::F3_BEQ:  cond = (rs1_i == rs2_i);
            isa_pkg::F3_BNE:  cond = (rs1_i != rs2_i);
            isa_pkg::F3_BLT:  cond = ($signed(rs1_i) < $signed(rs2_i));
            isa_pkg::F3_BGE:  cond = ($signed(rs1_i) >= $signed(rs2_i));
            isa_pkg::F3_BLTU: cond = (rs1_i < rs2_i);
            isa_pkg::F3_BGEU: cond = (rs1_i >= rs2_i);
            default:          cond = 1'b0;  // Reserved encodings never taken
        endcase
    end

    assign jalr_sum = rs1_i + imm_i;

    // Non-control-flow and illegal instructions never redirect
    assign redirect_o.taken  = (is_branch_i & cond) | is_jal_i | is_jalr_i;
    assign redirect_o.target = is_jalr_i ? {jalr_sum[`ID_XLEN-1:1], 1'b0} : pc_i + imm_i;

    assign link_o = is_lui_i ? imm_i : pc_i + `ID_XLEN'd4;

endmodule

//--- hdl/ctrl_decode.sv
`timescale 1ns/100ps

module ctrl_decode (
    input  isa_pkg::inst_fields_t inst_i,
    output pipe_pkg::id_ctrl_t    ctrl_o,
    output isa_pkg::imm_fmt_e     imm_fmt_o,
    output logic                  rs1_used_o,
    output logic                  rs2_used_o,
    output logic                  is_branch_o,
    output logic                  is_jal_o,
    output logic                  is_jalr_o,
    output logic                  is_lui_o
);

    // funct3 to ALU op, SUB only exists for register-register
    function automatic pipe_pkg::alu_op_e alu_sel(
        input logic [2:0] f3,
        input logic       sub_en,
        input logic       sra_en
    );
        case (f3)
            3'b000:  alu_sel = sub_en ? pipe_pkg::ALU_SUB : pipe_pkg::ALU_ADD;
            3'b001:  alu_sel = pipe_pkg::ALU_SLL;
            3'b010:  alu_sel = pipe_pkg::ALU_SLT;
            3'b011:  alu_sel = pipe_pkg::ALU_SLTU;
            3'b100:  alu_sel = pipe_pkg::ALU_XOR;
            3'b101:  alu_sel = sra_en ? pipe_pkg::ALU_SRA : pipe_pkg::ALU_SRL;
            3'b110:  alu_sel = pipe_pkg::ALU_OR;
            default: alu_sel = pipe_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.alu_op = pipe_pkg::ALU_ADD;
        ctrl_o.rd_idx = inst_i.rd;
        imm_fmt_o     = isa_pkg::IMM_NONE;
        rs1_used_o    = 1'b0;
        rs2_used_o    = 1'b0;
        is_branch_o   = 1'b0;
        is_jal_o      = 1'b0;
        is_jalr_o     = 1'b0;
        is_lui_o      = 1'b0;

        case (inst_i.opcode)
            isa_pkg::OPC_LUI: begin
                ctrl_o.alu_src_imm = 1'b1;  // rs1 reads zero, ALU passes imm
                ctrl_o.rd_en       = 1'b1;
                imm_fmt_o          = isa_pkg::IMM_U;
                is_lui_o           = 1'b1;
            end
            isa_pkg::OPC_AUIPC: begin
                ctrl_o.alu_src_pc  = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.rd_en       = 1'b1;
                imm_fmt_o          = isa_pkg::IMM_U;
            end
            isa_pkg::OPC_JAL: begin
                ctrl_o.rd_en = 1'b1;  // Writes link_data
                imm_fmt_o    = isa_pkg::IMM_J;
                is_jal_o     = 1'b1;
            end
            isa_pkg::OPC_JALR: begin
                ctrl_o.rd_en = 1'b1;
                imm_fmt_o    = isa_pkg::IMM_I;
                rs1_used_o   = 1'b1;
                is_jalr_o    = 1'b1;
            end
            isa_pkg::OPC_BRANCH: begin
                ctrl_o.alu_op = pipe_pkg::ALU_SUB;
                imm_fmt_o     = isa_pkg::IMM_B;
                rs1_used_o    = 1'b1;
                rs2_used_o    = 1'b1;
                is_branch_o   = 1'b1;
            end
            isa_pkg::OPC_LOAD: begin
                ctrl_o.alu_src_imm   = 1'b1;
                ctrl_o.rd_en         = 1'b1;
                ctrl_o.mem_read      = 1'b1;
                ctrl_o.mem_size      = pipe_pkg::mem_size_e'(inst_i.funct3[1:0]);
                ctrl_o.load_unsigned = inst_i.funct3[2];
                imm_fmt_o            = isa_pkg::IMM_I;
                rs1_used_o           = 1'b1;
            end
            isa_pkg::OPC_STORE: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.mem_write   = 1'b1;
                ctrl_o.mem_size    = pipe_pkg::mem_size_e'(inst_i.funct3[1:0]);
                imm_fmt_o          = isa_pkg::IMM_S;
                rs1_used_o         = 1'b1;
                rs2_used_o         = 1'b1;
            end
            isa_pkg::OPC_OP_IMM: begin
                // SRAI keeps funct7[5] in the upper immediate bits
                ctrl_o.alu_op      = alu_sel(inst_i.funct3, 1'b0, inst_i.funct7[5]);
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.rd_en       = 1'b1;
                imm_fmt_o          = isa_pkg::IMM_I;
                rs1_used_o         = 1'b1;
            end
            isa_pkg::OPC_OP: begin
                ctrl_o.alu_op = alu_sel(inst_i.funct3, inst_i.funct7[5], inst_i.funct7[5]);
                ctrl_o.rd_en  = 1'b1;
                rs1_used_o    = 1'b1;
                rs2_used_o    = 1'b1;
            end
            default: begin
                ctrl_o.illegal = 1'b1;
            end
        endcase
    end

endmodule

//--- hdl/id_macros.svh
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// Datapath width of the RV64I core
`define ID_XLEN 64

// Architectural integer registers
`define ID_NREGS 32

// log2 of ID_NREGS
`define ID_REG_IDX_W 5

// Base ISA instruction width, no compressed support
`define ID_INST_W 32

`endif

//--- hdl/id_stage.sv
`timescale 1ns/100ps
`include "id_macros.svh"

module id_stage (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  inst_valid_i,
    input  logic [`ID_INST_W-1:0] inst_i,
    input  logic [`ID_XLEN-1:0]   pc_i,
    input  pipe_pkg::bypass_t     byp_ex_i,
    input  pipe_pkg::bypass_t     byp_mem_i,
    input  pipe_pkg::bypass_t     byp_wb_i,
    output logic                  id_valid_o,
    output pipe_pkg::id_ctrl_t    ctrl_o,
    output pipe_pkg::id_opnd_t    opnd_o,
    output pipe_pkg::redirect_t   redirect_o
);

    isa_pkg::inst_fields_t fields;
    isa_pkg::imm_fmt_e     imm_fmt;
    pipe_pkg::id_ctrl_t    ctrl;
    pipe_pkg::id_opnd_t    opnd;
    pipe_pkg::redirect_t   redirect;

    logic [`ID_XLEN-1:0] rf_rs1;
    logic [`ID_XLEN-1:0] rf_rs2;
    logic [`ID_XLEN-1:0] fwd_rs1;
    logic [`ID_XLEN-1:0] fwd_rs2;
    logic [`ID_XLEN-1:0] imm;
    logic [`ID_XLEN-1:0] link;
    logic rs1_used;
    logic rs2_used;
    logic is_branch;
    logic is_jal;
    logic is_jalr;
    logic is_lui;

    assign fields = isa_pkg::inst_fields_t'(inst_i);

    assign opnd.pc        = pc_i;
    assign opnd.rs1_data  = fwd_rs1;
    assign opnd.rs2_data  = fwd_rs2;
    assign opnd.imm       = imm;
    assign opnd.link_data = link;

    reg_file reg_file_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_idx_i  (fields.rs1),
        .rs2_idx_i  (fields.rs2),
        .wr_i       (byp_wb_i),
        .rs1_data_o (rf_rs1),
        .rs2_data_o (rf_rs2)
    );

    ctrl_decode ctrl_decode_i (
        .inst_i      (fields),
        .ctrl_o      (ctrl),
        .imm_fmt_o   (imm_fmt),
        .rs1_used_o  (rs1_used),
        .rs2_used_o  (rs2_used),
        .is_branch_o (is_branch),
        .is_jal_o    (is_jal),
        .is_jalr_o   (is_jalr),
        .is_lui_o    (is_lui)
    );

    imm_gen imm_gen_i (
        .inst_i (fields),
        .fmt_i  (imm_fmt),
        .imm_o  (imm)
    );

    operand_forward operand_forward_i (
        .rs1_idx_i  (fields.rs1),
        .rs2_idx_i  (fields.rs2),
        .rs1_used_i (rs1_used),
        .rs2_used_i (rs2_used),
        .rf_rs1_i   (rf_rs1),
        .rf_rs2_i   (rf_rs2),
        .byp_ex_i   (byp_ex_i),
        .byp_mem_i  (byp_mem_i),
        .byp_wb_i   (byp_wb_i),
        .rs1_o      (fwd_rs1),
        .rs2_o      (fwd_rs2)
    );

    branch_unit branch_unit_i (
        .pc_i        (pc_i),
        .rs1_i       (fwd_rs1),
        .rs2_i       (fwd_rs2),
        .imm_i       (imm),
        .funct3_i    (isa_pkg::br_funct3_e'(fields.funct3)),
        .is_branch_i (is_branch),
        .is_jal_i    (is_jal),
        .is_jalr_i   (is_jalr),
        .is_lui_i    (is_lui),
        .redirect_o  (redirect),
        .link_o      (link)
    );

    // Only the control register reports valid
    pipe_reg #(.T(pipe_pkg::id_ctrl_t)) ctrl_reg_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (inst_valid_i),
        .d_i     (ctrl),
        .valid_o (id_valid_o),
        .q_o     (ctrl_o)
    );

    pipe_reg #(.T(pipe_pkg::id_opnd_t)) opnd_reg_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (inst_valid_i),
        .d_i     (opnd),
        .valid_o (),
        .q_o     (opnd_o)
    );

    pipe_reg #(.T(pipe_pkg::redirect_t)) redirect_reg_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (inst_valid_i),
        .d_i     (redirect),
        .valid_o (),
        .q_o     (redirect_o)
    );

endmodule

//--- hdl/imm_gen.sv
`timescale 1ns/100ps
`include "id_macros.svh"

module imm_gen (
    input  isa_pkg::inst_fields_t inst_i,
    input  isa_pkg::imm_fmt_e     fmt_i,
    output logic [`ID_XLEN-1:0]   imm_o
);

    logic [`ID_INST_W-1:0] raw;

    assign raw = inst_i;

    always_comb begin
        case (fmt_i)
            isa_pkg::IMM_I: imm_o = {{(`ID_XLEN-12){raw[31]}}, raw[31:20]};
            isa_pkg::IMM_S: imm_o = {{(`ID_XLEN-12){raw[31]}}, raw[31:25], raw[11:7]};
            isa_pkg::IMM_B: begin
                imm_o = {{(`ID_XLEN-13){raw[31]}}, raw[31], raw[7], raw[30:25],
                         raw[11:8], 1'b0};
            end
            isa_pkg::IMM_U: imm_o = {{(`ID_XLEN-32){raw[31]}}, raw[31:12], 12'b0};
            isa_pkg::IMM_J: begin
                imm_o = {{(`ID_XLEN-21){raw[31]}}, raw[31], raw[19:12], raw[20],
                         raw[30:21], 1'b0};
            end
            default: imm_o = '0;  // R-type and illegal
        endcase
    end

endmodule

//--- hdl/isa_pkg.sv
`include "id_macros.svh"

package isa_pkg;

    // Major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // Conditional branch funct3, 010 and 011 are reserved
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } br_funct3_e;

    // R-type overlay, other formats reuse the same bit positions
    typedef struct packed {
        logic [6:0]               funct7;
        logic [`ID_REG_IDX_W-1:0] rs2;
        logic [`ID_REG_IDX_W-1:0] rs1;
        logic [2:0]               funct3;
        logic [`ID_REG_IDX_W-1:0] rd;
        opcode_e                  opcode;
    } inst_fields_t;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_NONE
    } imm_fmt_e;

endpackage

//--- hdl/operand_forward.sv
`timescale 1ns/100ps
`include "id_macros.svh"

module operand_forward (
    input  logic [`ID_REG_IDX_W-1:0] rs1_idx_i,
    input  logic [`ID_REG_IDX_W-1:0] rs2_idx_i,
    input  logic                     rs1_used_i,
    input  logic                     rs2_used_i,
    input  logic [`ID_XLEN-1:0]      rf_rs1_i,
    input  logic [`ID_XLEN-1:0]      rf_rs2_i,
    input  pipe_pkg::bypass_t        byp_ex_i,
    input  pipe_pkg::bypass_t        byp_mem_i,
    input  pipe_pkg::bypass_t        byp_wb_i,
    output logic [`ID_XLEN-1:0]      rs1_o,
    output logic [`ID_XLEN-1:0]      rs2_o
);

    function automatic logic hit(
        input pipe_pkg::bypass_t        byp,
        input logic [`ID_REG_IDX_W-1:0] idx
    );
        hit = byp.rd_en && (byp.rd_idx != '0) && (byp.rd_idx == idx);
    endfunction

    // Youngest producer wins
    function automatic logic [`ID_XLEN-1:0] pick(
        input logic [`ID_REG_IDX_W-1:0] idx,
        input logic                     used,
        input logic [`ID_XLEN-1:0]      rf
    );
        if (!used)                       pick = '0;
        else if (hit(byp_ex_i, idx))     pick = byp_ex_i.rd_data;
        else if (hit(byp_mem_i, idx))    pick = byp_mem_i.rd_data;
        else if (hit(byp_wb_i, idx))     pick = byp_wb_i.rd_data;  // Write not in file yet
        else                             pick = rf;
    endfunction

    assign rs1_o = pick(rs1_idx_i, rs1_used_i, rf_rs1_i);
    assign rs2_o = pick(rs2_idx_i, rs2_used_i, rf_rs2_i);

endmodule

//--- hdl/pipe_pkg.sv
`include "id_macros.svh"

package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // Matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_B = 2'b00,
        MEM_H = 2'b01,
        MEM_W = 2'b10,
        MEM_D = 2'b11
    } mem_size_e;

    // Result of a younger stage, WB doubles as regfile write port
    typedef struct packed {
        logic                     rd_en;
        logic [`ID_REG_IDX_W-1:0] rd_idx;
        logic [`ID_XLEN-1:0]      rd_data;
    } bypass_t;

    typedef struct packed {
        alu_op_e                  alu_op;
        logic                     alu_src_pc;   // Operand A is pc
        logic                     alu_src_imm;  // Operand B is imm
        logic                     rd_en;
        logic [`ID_REG_IDX_W-1:0] rd_idx;
        logic                     mem_read;
        logic                     mem_write;
        mem_size_e                mem_size;
        logic                     load_unsigned;
        logic                     illegal;
    } id_ctrl_t;

    typedef struct packed {
        logic [`ID_XLEN-1:0] pc;
        logic [`ID_XLEN-1:0] rs1_data;
        logic [`ID_XLEN-1:0] rs2_data;
        logic [`ID_XLEN-1:0] imm;
        logic [`ID_XLEN-1:0] link_data;  // pc+4, or imm for LUI
    } id_opnd_t;

    typedef struct packed {
        logic                taken;
        logic [`ID_XLEN-1:0] target;
    } redirect_t;

endpackage

//--- hdl/pipe_reg.sv
`timescale 1ns/100ps

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic valid_i,
    input  T     d_i,
    output logic valid_o,
    output T     q_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            q_o     <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                q_o <= d_i;  // Bubbles keep last payload
            end
        end
    end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/100ps
`include "id_macros.svh"

module reg_file (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic [`ID_REG_IDX_W-1:0] rs1_idx_i,
    input  logic [`ID_REG_IDX_W-1:0] rs2_idx_i,
    input  pipe_pkg::bypass_t        wr_i,
    output logic [`ID_XLEN-1:0]      rs1_data_o,
    output logic [`ID_XLEN-1:0]      rs2_data_o
);

    logic [`ID_XLEN-1:0] regs [`ID_NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `ID_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.rd_en && (wr_i.rd_idx != '0)) begin
            regs[wr_i.rd_idx] <= wr_i.rd_data;
        end
    end

    // x0 reads zero regardless of array content
    assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

endmodule

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module tb_id_stage \
    -f files.f -o sim_id_stage > sim.log 2>&1 &&
    ./obj_dir/sim_id_stage >> sim.log 2>&1
cat sim.log
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

//--- tb/tb_id_stage.sv
`timescale 1ns/100ps
`include "id_macros.svh"

module tb_id_stage;

    localparam int NUM_RANDOM = 600;

    logic                  clk = 1'b0;
    logic                  rst_n_i;
    logic                  inst_valid_i;
    logic [`ID_INST_W-1:0] inst_i;
    logic [`ID_XLEN-1:0]   pc_i;
    pipe_pkg::bypass_t     byp_ex_i;
    pipe_pkg::bypass_t     byp_mem_i;
    pipe_pkg::bypass_t     byp_wb_i;
    logic                  id_valid_o;
    pipe_pkg::id_ctrl_t    ctrl_o;
    pipe_pkg::id_opnd_t    opnd_o;
    pipe_pkg::redirect_t   redirect_o;

    int seed = 32'h6617_bc97;

    // Reference state, updated on the falling edge
    logic [`ID_XLEN-1:0] shadow [`ID_NREGS];
    logic                exp_valid;
    pipe_pkg::id_ctrl_t  exp_ctrl;
    pipe_pkg::id_opnd_t  exp_opnd;
    pipe_pkg::redirect_t exp_redir;
    logic                have_exp = 1'b0;

    id_stage id_stage_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .byp_ex_i     (byp_ex_i),
        .byp_mem_i    (byp_mem_i),
        .byp_wb_i     (byp_wb_i),
        .id_valid_o   (id_valid_o),
        .ctrl_o       (ctrl_o),
        .opnd_o       (opnd_o),
        .redirect_o   (redirect_o)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_field(input string name, input logic [`ID_XLEN-1:0] got,
                                 input logic [`ID_XLEN-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        compare_field("id_valid_o", `ID_XLEN'(got), `ID_XLEN'(exp));
    endtask

    task automatic check_ctrl(input pipe_pkg::id_ctrl_t got, input pipe_pkg::id_ctrl_t exp);
        compare_field("ctrl_o.alu_op", `ID_XLEN'(got.alu_op), `ID_XLEN'(exp.alu_op));
        compare_field("ctrl_o.alu_src_pc", `ID_XLEN'(got.alu_src_pc), `ID_XLEN'(exp.alu_src_pc));
        compare_field("ctrl_o.alu_src_imm", `ID_XLEN'(got.alu_src_imm),
                      `ID_XLEN'(exp.alu_src_imm));
        compare_field("ctrl_o.rd_en", `ID_XLEN'(got.rd_en), `ID_XLEN'(exp.rd_en));
        compare_field("ctrl_o.rd_idx", `ID_XLEN'(got.rd_idx), `ID_XLEN'(exp.rd_idx));
        compare_field("ctrl_o.mem_read", `ID_XLEN'(got.mem_read), `ID_XLEN'(exp.mem_read));
        compare_field("ctrl_o.mem_write", `ID_XLEN'(got.mem_write), `ID_XLEN'(exp.mem_write));
        compare_field("ctrl_o.mem_size", `ID_XLEN'(got.mem_size), `ID_XLEN'(exp.mem_size));
        compare_field("ctrl_o.load_unsigned", `ID_XLEN'(got.load_unsigned),
                      `ID_XLEN'(exp.load_unsigned));
        compare_field("ctrl_o.illegal", `ID_XLEN'(got.illegal), `ID_XLEN'(exp.illegal));
    endtask

    task automatic check_opnd(input pipe_pkg::id_opnd_t got, input pipe_pkg::id_opnd_t exp);
        compare_field("opnd_o.pc", got.pc, exp.pc);
        compare_field("opnd_o.rs1_data", got.rs1_data, exp.rs1_data);
        compare_field("opnd_o.rs2_data", got.rs2_data, exp.rs2_data);
        compare_field("opnd_o.imm", got.imm, exp.imm);
        compare_field("opnd_o.link_data", got.link_data, exp.link_data);
    endtask

    task automatic check_redirect(input pipe_pkg::redirect_t got,
                                  input pipe_pkg::redirect_t exp);
        compare_field("redirect_o.taken", `ID_XLEN'(got.taken), `ID_XLEN'(exp.taken));
        compare_field("redirect_o.target", got.target, exp.target);
    endtask

    // Later matches override earlier ones, so EX ends up on top
    function automatic logic [`ID_XLEN-1:0] operand_value(
        input logic [`ID_REG_IDX_W-1:0] idx,
        input logic                     used,
        input pipe_pkg::bypass_t        ex,
        input pipe_pkg::bypass_t        mem,
        input pipe_pkg::bypass_t        wb
    );
        logic [`ID_XLEN-1:0] val;
        val = shadow[idx];
        if (wb.rd_en && wb.rd_idx == idx) val = wb.rd_data;
        if (mem.rd_en && mem.rd_idx == idx) val = mem.rd_data;
        if (ex.rd_en && ex.rd_idx == idx) val = ex.rd_data;
        if (!used || idx == '0) val = '0;
        return val;
    endfunction

    function automatic pipe_pkg::alu_op_e base_alu(input logic [2:0] f3);
        pipe_pkg::alu_op_e ops [8];
        ops = '{pipe_pkg::ALU_ADD, pipe_pkg::ALU_SLL, pipe_pkg::ALU_SLT, pipe_pkg::ALU_SLTU,
                pipe_pkg::ALU_XOR, pipe_pkg::ALU_SRL, pipe_pkg::ALU_OR, pipe_pkg::ALU_AND};
        return ops[f3];
    endfunction

    function automatic void predict(
        input  logic [`ID_INST_W-1:0] inst,
        input  logic [`ID_XLEN-1:0]   pc,
        input  pipe_pkg::bypass_t     ex,
        input  pipe_pkg::bypass_t     mem,
        input  pipe_pkg::bypass_t     wb,
        output pipe_pkg::id_ctrl_t    c,
        output pipe_pkg::id_opnd_t    o,
        output pipe_pkg::redirect_t   r
    );
        logic [2:0]          f3;
        logic                use1;
        logic                use2;
        logic                br;
        logic                jal;
        logic                jalr;
        logic                lui;
        logic                cond;
        logic [`ID_XLEN-1:0] imm;
        logic [`ID_XLEN-1:0] imm_i;
        logic [`ID_XLEN-1:0] imm_s;
        logic [`ID_XLEN-1:0] imm_b;
        logic [`ID_XLEN-1:0] imm_u;
        logic [`ID_XLEN-1:0] imm_j;
        f3    = inst[14:12];
        imm_i = `ID_XLEN'($signed(inst[31:20]));
        imm_s = `ID_XLEN'($signed({inst[31:25], inst[11:7]}));
        imm_b = `ID_XLEN'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
        imm_u = `ID_XLEN'($signed({inst[31:12], 12'h000}));
        imm_j = `ID_XLEN'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
        {use1, use2, br, jal, jalr, lui} = '0;
        imm      = '0;
        c        = '0;
        c.alu_op = pipe_pkg::ALU_ADD;
        c.rd_idx = inst[11:7];
        case (inst[6:0])
            isa_pkg::OPC_LUI: begin
                {c.alu_src_imm, c.rd_en, lui} = 3'b111;
                imm = imm_u;
            end
            isa_pkg::OPC_AUIPC: begin
                {c.alu_src_pc, c.alu_src_imm, c.rd_en} = 3'b111;
                imm = imm_u;
            end
            isa_pkg::OPC_JAL: begin
                {c.rd_en, jal} = 2'b11;
                imm = imm_j;
            end
            isa_pkg::OPC_JALR: begin
                {c.rd_en, use1, jalr} = 3'b111;
                imm = imm_i;
            end
            isa_pkg::OPC_BRANCH: begin
                c.alu_op = pipe_pkg::ALU_SUB;
                {use1, use2, br} = 3'b111;
                imm = imm_b;
            end
            isa_pkg::OPC_LOAD: begin
                {c.alu_src_imm, c.rd_en, c.mem_read, use1} = 4'b1111;
                c.mem_size      = pipe_pkg::mem_size_e'(f3[1:0]);
                c.load_unsigned = f3[2];
                imm = imm_i;
            end
            isa_pkg::OPC_STORE: begin
                {c.alu_src_imm, c.mem_write, use1, use2} = 4'b1111;
                c.mem_size = pipe_pkg::mem_size_e'(f3[1:0]);
                imm = imm_s;
            end
            isa_pkg::OPC_OP_IMM: begin
                c.alu_op = (f3 == 3'b101 && inst[30]) ? pipe_pkg::ALU_SRA : base_alu(f3);
                {c.alu_src_imm, c.rd_en, use1} = 3'b111;
                imm = imm_i;
            end
            isa_pkg::OPC_OP: begin
                c.alu_op = base_alu(f3);
                if (inst[30] && f3 == 3'b000) c.alu_op = pipe_pkg::ALU_SUB;
                if (inst[30] && f3 == 3'b101) c.alu_op = pipe_pkg::ALU_SRA;
                {c.rd_en, use1, use2} = 3'b111;
            end
            default: c.illegal = 1'b1;
        endcase
        o.pc       = pc;
        o.imm      = imm;
        o.rs1_data = operand_value(inst[19:15], use1, ex, mem, wb);
        o.rs2_data = operand_value(inst[24:20], use2, ex, mem, wb);
        case (f3)
            3'b000:  cond = (o.rs1_data == o.rs2_data);
            3'b001:  cond = (o.rs1_data != o.rs2_data);
            3'b100:  cond = ($signed(o.rs1_data) < $signed(o.rs2_data));
            3'b101:  cond = !($signed(o.rs1_data) < $signed(o.rs2_data));
            3'b110:  cond = (o.rs1_data < o.rs2_data);
            3'b111:  cond = !(o.rs1_data < o.rs2_data);
            default: cond = 1'b0;
        endcase
        r.taken     = (br && cond) || jal || jalr;
        r.target    = jalr ? ((o.rs1_data + imm) & ~`ID_XLEN'd1) : (pc + imm);
        o.link_data = lui ? imm : (pc + `ID_XLEN'd4);
    endfunction

    // Small index range so sources and bypasses collide often
    function automatic logic [`ID_REG_IDX_W-1:0] near_idx();
        return `ID_REG_IDX_W'($unsigned($random(seed)) % 6);
    endfunction

    function automatic logic [`ID_XLEN-1:0] pick_data();
        case ($unsigned($random(seed)) % 5)
            0:       return '0;
            1:       return `ID_XLEN'd1;
            2:       return '1;
            3:       return {1'b1, {(`ID_XLEN-1){1'b0}}};  // Most negative
            default: return {$random(seed), $random(seed)};
        endcase
    endfunction

    function automatic pipe_pkg::bypass_t make_bypass();
        pipe_pkg::bypass_t b;
        logic [31:0]       r;
        r         = $random(seed);
        b.rd_en   = r[0];
        b.rd_idx  = near_idx();
        b.rd_data = pick_data();
        return b;
    endfunction

    task automatic drive_random();
        logic [31:0] r;
        logic [6:0]  opc;
        r = $random(seed);
        case ($unsigned($random(seed)) % 11)
            0:       opc = isa_pkg::OPC_LUI;
            1:       opc = isa_pkg::OPC_AUIPC;
            2:       opc = isa_pkg::OPC_JAL;
            3:       opc = isa_pkg::OPC_JALR;
            4:       opc = isa_pkg::OPC_BRANCH;
            5:       opc = isa_pkg::OPC_LOAD;
            6:       opc = isa_pkg::OPC_STORE;
            7:       opc = isa_pkg::OPC_OP_IMM;
            8:       opc = isa_pkg::OPC_OP;
            9:       opc = 7'b0011011;  // OP-IMM-32
            default: opc = 7'b1110011;  // SYSTEM
        endcase
        inst_valid_i <= ($unsigned($random(seed)) % 8) != 0;
        inst_i       <= {r[31:25], near_idx(), near_idx(), r[14:12], r[11:7], opc};
        pc_i         <= {$random(seed), $random(seed)} & ~`ID_XLEN'h3;
        byp_ex_i     <= make_bypass();
        byp_mem_i    <= make_bypass();
        byp_wb_i     <= make_bypass();
    endtask

    // Compare what the DUT took at the last rising edge, then predict the next one
    always @(negedge clk) begin
        if (have_exp) begin
            check_valid(id_valid_o, exp_valid);
            check_ctrl(ctrl_o, exp_ctrl);
            check_opnd(opnd_o, exp_opnd);
            check_redirect(redirect_o, exp_redir);
        end
        if (!rst_n_i) begin
            exp_valid = 1'b0;
            exp_ctrl  = '0;
            exp_opnd  = '0;
            exp_redir = '0;
            for (int i = 0; i < `ID_NREGS; i++) begin
                shadow[i] = '0;
            end
        end else begin
            exp_valid = inst_valid_i;
            if (inst_valid_i) begin
                predict(inst_i, pc_i, byp_ex_i, byp_mem_i, byp_wb_i,
                        exp_ctrl, exp_opnd, exp_redir);
            end
            if (byp_wb_i.rd_en && byp_wb_i.rd_idx != '0) begin
                shadow[byp_wb_i.rd_idx] = byp_wb_i.rd_data;
            end
        end
        have_exp = 1'b1;
    end

    initial begin
        int   cycles;
        logic seen;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        byp_ex_i     = '0;
        byp_mem_i    = '0;
        byp_wb_i     = '0;
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;

        // Single addi x1, x0, 2047 to measure latency
        @(posedge clk);
        inst_valid_i <= 1'b1;
        inst_i       <= {12'h7ff, 5'd0, 3'b000, 5'd1, isa_pkg::OPC_OP_IMM};
        pc_i         <= `ID_XLEN'h1000;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 10) begin
            @(posedge clk);
            inst_valid_i <= 1'b0;
            cycles++;
            @(negedge clk);
            seen = id_valid_o;
        end
        if (!seen) begin
            abort_run("id_valid_o never rose after a valid instruction");
        end else if (cycles != 1) begin
            abort_run($sformatf("id_valid_o rose after %0d cycles instead of 1", cycles));
        end

        repeat (NUM_RANDOM) begin
            @(posedge clk);
            drive_random();
        end

        @(posedge clk);
        inst_valid_i <= 1'b0;
        cycles = 0;
        seen   = 1'b1;
        while (seen && cycles < 10) begin
            @(negedge clk);
            cycles++;
            seen = id_valid_o;
        end
        if (seen) begin
            abort_run("id_valid_o stayed high after the input went idle");
        end else begin
            @(posedge clk);
            $display("Everything OK");
            $finish;
        end
    end

endmodule
